//--- filelist.f
+incdir+dv
verilog/radio_ctrl_pkg.sv
verilog/settings_port.sv
verilog/misc_ctrl_regs.sv
verilog/txrx_switch.sv
verilog/vita_timer.sv
verilog/readback_mux.sv
verilog/radio_ctrl_core.sv
dv/tb_clkgen.sv
dv/radio_ctrl_tb.sv

//--- dv/radio_ctrl_tb_ref.svh
// Reference models, random source and compare task for the testbench.
// Included inside the testbench top, which owns lfsr_state and report_failure.

`ifndef RADIO_CTRL_TB_REF_SVH
`define RADIO_CTRL_TB_REF_SVH

// Galois LFSR, one step per call
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
   lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// One LFSR step for each bit taken
function automatic logic [31:0] take_bits(input int n);
   logic [31:0] v;
   v = '0;
   for (int b = 0; b < n; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
   end
   take_bits = v;
endfunction

// LED word, hardware status where the mask is set
function automatic logic [7:0] exp_leds(input logic [7:0] src, input logic [7:0] sw,
                                        input logic tx, input logic rx,
                                        input logic clk_ok, input logic link);
   logic [7:0] hw;
   logic [7:0] out;
   hw = 8'h00;
   hw[4] = tx;
   hw[3] = rx;
   hw[2] = clk_ok;
   hw[1] = link;
   for (int b = 0; b < 8; b++) begin
      out[b] = src[b] ? hw[b] : sw[b];
   end
   exp_leds = out;
endfunction

function automatic logic [31:0] exp_irq(input logic button, input logic clk_ok,
                                        input logic link);
   logic [31:0] w;
   w = 32'h0;
   w[13] = button;
   w[11] = clk_ok;
   w[10] = link;
   exp_irq = w;
endfunction

// Receive word is replaced by the -1,-1 sample in TX mode
function automatic logic [31:0] exp_rx_sample(input logic tx, input logic [31:0] rx_in);
   exp_rx_sample = tx ? 32'h8001_8001 : rx_in;
endfunction

task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string msg);
   if (got !== exp) begin
      report_failure($sformatf("Mismatch at %0t: %s, got %h expected %h",
                               $time, msg, got, exp));
   end
endtask

`endif

//--- dv/radio_ctrl_tb.sv
// Testbench top for the radio control core. Drives settings writes,
// readbacks, magic samples, run inputs and PPS, and compares the DUT
// outputs with reference functions in a separate comparison process.

module radio_ctrl_tb
   import radio_ctrl_pkg::*;
();

   localparam int TIMEOUT_CYCLES = 100;

   logic dsp_clk, por_rst;
   logic set_req_i, set_ack_o, rb_req_i, rb_ack_o;
   set_req_t set_i;
   logic [RB_AW-1:0] rb_addr_i;
   logic [31:0] rb_data_o;
   sample_u tx_sample_i, rx_sample_i, rx_sample_o;
   logic run_rx0_i, run_rx1_i, clk_status_i, link_up_i, button_i, pps_i;
   atr_t atr_o;
   clock_ctrl_t clock_ctrl_o;
   serdes_ctrl_t serdes_ctrl_o;
   adc_ctrl_t adc_ctrl_o;
   logic phy_reset_n_o;
   logic [7:0] leds_o;

   logic [31:0] lfsr_state = 32'hd100;
   longint cycle_cnt = 0;

   // Expected register state
   logic [4:0] m_clk = '0;
   logic [3:0] m_serdes = '0;
   logic [3:0] m_adc = '0;
   logic m_phy = 1'b0;
   logic m_tx = 1'b0;
   logic m_rx = 1'b0;
   logic [7:0] m_sw = '0;
   logic [7:0] m_src = 8'h1e;

   logic [63:0] got_q[$];
   logic [63:0] exp_q[$];
   string msg_q[$];

   task automatic report_failure(input string what);
      $display("%s", what);
      $display("*** FAILED ***");
      $fatal(1);
   endtask

   `include "radio_ctrl_tb_ref.svh"

   tb_clkgen #(.PERIOD(8), .RST_CYCLES(16)) i_tb_clkgen (
      .dsp_clk_o (dsp_clk),
      .por_rst_o (por_rst)
   );

   radio_ctrl_core i_radio_ctrl_core (
      .dsp_clk       (dsp_clk),
      .por_rst       (por_rst),
      .set_req_i     (set_req_i),
      .set_i         (set_i),
      .rb_req_i      (rb_req_i),
      .rb_addr_i     (rb_addr_i),
      .tx_sample_i   (tx_sample_i),
      .rx_sample_i   (rx_sample_i),
      .run_rx0_i     (run_rx0_i),
      .run_rx1_i     (run_rx1_i),
      .clk_status_i  (clk_status_i),
      .link_up_i     (link_up_i),
      .button_i      (button_i),
      .pps_i         (pps_i),
      .set_ack_o     (set_ack_o),
      .rb_ack_o      (rb_ack_o),
      .rb_data_o     (rb_data_o),
      .rx_sample_o   (rx_sample_o),
      .atr_o         (atr_o),
      .clock_ctrl_o  (clock_ctrl_o),
      .serdes_ctrl_o (serdes_ctrl_o),
      .adc_ctrl_o    (adc_ctrl_o),
      .phy_reset_n_o (phy_reset_n_o),
      .leds_o        (leds_o)
   );

   always @(posedge dsp_clk) cycle_cnt <= cycle_cnt + 1;

   // Comparison process, away from the driving edge
   always @(negedge dsp_clk) begin
      while (got_q.size() > 0) begin
         check_value(got_q.pop_front(), exp_q.pop_front(), msg_q.pop_front());
      end
   end

   task automatic tick(input int n);
      repeat (n) @(posedge dsp_clk);
      #1;
   endtask

   task automatic expect_value(input logic [63:0] got, input logic [63:0] exp,
                               input string msg);
      got_q.push_back(got);
      exp_q.push_back(exp);
      msg_q.push_back(msg);
   endtask

   task automatic wait_ack(input bit rb, input logic level, input string what);
      int cnt;
      cnt = 0;
      while ((rb ? rb_ack_o : set_ack_o) !== level) begin
         tick(1);
         cnt++;
         if (cnt > TIMEOUT_CYCLES) report_failure({"Timeout waiting for ", what});
      end
   endtask

   task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
      set_i = '{addr: addr, data: data};
      set_req_i = 1'b1;
      wait_ack(1'b0, 1'b1, "settings ack");
      set_req_i = 1'b0;
      wait_ack(1'b0, 1'b0, "settings ack release");
      case (addr)
         SR_MISC_DEF + 0: m_clk = data[4:0];
         SR_MISC_DEF + 1: m_serdes = data[3:0];
         SR_MISC_DEF + 2: m_adc = data[3:0];
         SR_MISC_DEF + 3: m_sw = data[7:0];
         SR_MISC_DEF + 4: m_phy = data[0];
         SR_MISC_DEF + 6: m_src = data[7:0];
         default: ;
      endcase
   endtask

   task automatic read_back(input logic [3:0] addr, output logic [31:0] data,
                            output longint ack_cycle);
      rb_addr_i = addr;
      rb_req_i = 1'b1;
      wait_ack(1'b1, 1'b1, "readback ack");
      data = rb_data_o;
      ack_cycle = cycle_cnt;
      rb_req_i = 1'b0;
      wait_ack(1'b1, 1'b0, "readback ack release");
   endtask

   task automatic check_outputs(input string tag);
      expect_value(clock_ctrl_o, m_clk, {tag, " clock_ctrl"});
      expect_value(serdes_ctrl_o, m_serdes, {tag, " serdes_ctrl"});
      expect_value(adc_ctrl_o, m_adc, {tag, " adc_ctrl"});
      expect_value(phy_reset_n_o, !m_phy, {tag, " phy_reset_n"});
      expect_value(atr_o, {m_tx, m_rx}, {tag, " atr"});
      expect_value(leds_o, exp_leds(m_src, m_sw, m_tx, m_rx, clk_status_i, link_up_i),
                   {tag, " leds"});
   endtask

   ///////////////////////////////////////////////////////////////////////
   // Stimulus

   initial begin
      int cnt;
      logic [31:0] data, hi, lo, v1, v2, p;
      longint c1, c2, c_unused;
      int misc_offs[6];
      misc_offs = '{0, 1, 2, 3, 4, 6};
      set_req_i = 1'b0;
      set_i = '0;
      rb_req_i = 1'b0;
      rb_addr_i = '0;
      tx_sample_i = '0;
      rx_sample_i = '0;
      run_rx0_i = 1'b0;
      run_rx1_i = 1'b0;
      clk_status_i = 1'b1;
      link_up_i = 1'b0;
      button_i = 1'b0;
      pps_i = 1'b0;
      cnt = 0;
      while (por_rst !== 1'b0) begin
         tick(1);
         cnt++;
         if (cnt > TIMEOUT_CYCLES) report_failure("Reset was never released");
      end
      tick(2);
      check_outputs("reset");

      // Misc registers and unused addresses
      for (int r = 0; r < 4; r++) begin
         foreach (misc_offs[k]) begin
            write_setting(8'(SR_MISC_DEF + misc_offs[k]), take_bits(32));
            check_outputs("misc write");
         end
      end
      write_setting(8'd5, take_bits(32));
      write_setting(8'd50, take_bits(32));
      check_outputs("unused write");

      // LED mix
      for (int r = 0; r < 8; r++) begin
         write_setting(8'(SR_MISC_DEF + 6), take_bits(8));
         write_setting(8'(SR_MISC_DEF + 3), take_bits(8));
         {clk_status_i, link_up_i} = take_bits(2);
         tick(1);
         check_outputs("led mix");
      end

      // Magic samples and run inputs, mask shows bits 4 and 3
      write_setting(8'(SR_MISC_DEF + 6), 32'h18);
      tx_sample_i.raw = 32'h8001_8001;
      tick(2);
      m_tx = 1'b1;
      check_outputs("tx mode");
      tx_sample_i.raw = take_bits(32) & 32'h0fff_0fff;
      for (int r = 0; r < 4; r++) begin
         rx_sample_i.raw = take_bits(32);
         tick(2);
         expect_value(rx_sample_o.raw, exp_rx_sample(m_tx, rx_sample_i.raw), "rx in tx mode");
      end
      tx_sample_i.raw = 32'h7fff_7fff;
      tick(2);
      m_tx = 1'b0;
      check_outputs("rx mode");
      for (int r = 0; r < 4; r++) begin
         rx_sample_i.raw = take_bits(32);
         tick(2);
         expect_value(rx_sample_o.raw, exp_rx_sample(m_tx, rx_sample_i.raw), "rx in rx mode");
      end
      for (int r = 0; r < 4; r++) begin
         {run_rx1_i, run_rx0_i} = 2'(r);
         tick(2);
         m_rx = run_rx0_i | run_rx1_i;
         check_outputs("run inputs");
      end

      // Readback slots
      read_back(4'd0, data, c_unused);
      expect_value(data, {16'd10, 16'd1}, "compat number");
      for (int r = 0; r < 4; r++) begin
         {button_i, clk_status_i, link_up_i} = take_bits(3);
         tick(1);
         read_back(4'd1, data, c_unused);
         expect_value(data, exp_irq(button_i, clk_status_i, link_up_i), "irq word");
      end
      for (int s = 6; s < 16; s++) begin
         read_back(4'(s), data, c_unused);
         expect_value(data, 32'hffff_ffff, "unused readback slot");
      end

      // Time set, count and PPS capture
      hi = take_bits(32);
      lo = take_bits(31);
      write_setting(8'(SR_TIME64_DEF + 0), hi);
      write_setting(8'(SR_TIME64_DEF + 1), lo);
      read_back(4'd2, data, c_unused);
      expect_value(data, hi, "time high");
      read_back(4'd3, v1, c1);
      pps_i = 1'b1;
      tick(3);
      pps_i = 1'b0;
      tick(5 + int'(take_bits(4)));
      read_back(4'd3, v2, c2);
      expect_value(v2 - v1, 32'(c2 - c1), "time low step");
      read_back(4'd5, p, c_unused);
      expect_value((p > v1) && (p < v2), 1'b1, "pps low between reads");
      read_back(4'd4, data, c_unused);
      expect_value(data, hi, "pps high");

      cnt = 0;
      while (got_q.size() > 0) begin
         tick(1);
         cnt++;
         if (cnt > TIMEOUT_CYCLES) report_failure("Comparison queue did not drain");
      end
      tick(1);
      $display("*** PASSED ***");
      $finish;
   end

endmodule

//--- dv/tb_clkgen.sv
// Testbench clock and reset source for the radio control core.
// Makes dsp_clk and holds por_rst high for a fixed number of rising edges.

module tb_clkgen #(
   parameter int PERIOD     = 8,
   parameter int RST_CYCLES = 16
) (
   output logic dsp_clk_o,
   output logic por_rst_o
);

   initial begin
      dsp_clk_o = 1'b0;
      forever #(PERIOD / 2) dsp_clk_o = ~dsp_clk_o;
   end

   // Release lands just after a rising edge, like the other stimulus
   initial begin
      por_rst_o = 1'b1;
      repeat (RST_CYCLES) @(posedge dsp_clk_o);
      #1 por_rst_o = 1'b0;
   end

endmodule

//--- verilog/radio_ctrl_core.sv
// Top of the dsp_clk control plane. Connects the settings port, misc
// registers, TX/RX switch, time counter and readback port. Base addresses
// of the register groups are set here and handed to the decoding blocks.

module radio_ctrl_core
   import radio_ctrl_pkg::*;
#(
   parameter int SR_MISC   = SR_MISC_DEF,
   parameter int SR_TIME64 = SR_TIME64_DEF
) (
   input  logic             dsp_clk,
   input  logic             por_rst,
   input  logic             set_req_i,
   input  set_req_t         set_i,
   input  logic             rb_req_i,
   input  logic [RB_AW-1:0] rb_addr_i,
   input  sample_u          tx_sample_i,
   input  sample_u          rx_sample_i,
   input  logic             run_rx0_i,
   input  logic             run_rx1_i,
   input  logic             clk_status_i,
   input  logic             link_up_i,
   input  logic             button_i,
   input  logic             pps_i,
   output logic             set_ack_o,
   output logic             rb_ack_o,
   output logic [31:0]      rb_data_o,
   output sample_u          rx_sample_o,
   output atr_t             atr_o,
   output clock_ctrl_t      clock_ctrl_o,
   output serdes_ctrl_t     serdes_ctrl_o,
   output adc_ctrl_t        adc_ctrl_o,
   output logic             phy_reset_n_o,
   output logic [7:0]       leds_o
);

   logic        set_stb;
   set_req_t    set_data;
   logic        tx_mode;
   logic        rx_active;
   logic [63:0] vita_time;
   logic [63:0] vita_time_pps;

   settings_port i_settings_port (
      .dsp_clk   (dsp_clk),
      .por_rst   (por_rst),
      .set_req_i (set_req_i),
      .set_i     (set_i),
      .set_ack_o (set_ack_o),
      .set_stb_o (set_stb),
      .set_o     (set_data)
   );

   misc_ctrl_regs #(.SR_MISC(SR_MISC)) i_misc_ctrl_regs (
      .dsp_clk       (dsp_clk),
      .por_rst       (por_rst),
      .set_stb_i     (set_stb),
      .set_i         (set_data),
      .tx_mode_i     (tx_mode),
      .rx_active_i   (rx_active),
      .clk_status_i  (clk_status_i),
      .link_up_i     (link_up_i),
      .clock_ctrl_o  (clock_ctrl_o),
      .serdes_ctrl_o (serdes_ctrl_o),
      .adc_ctrl_o    (adc_ctrl_o),
      .phy_reset_n_o (phy_reset_n_o),
      .leds_o        (leds_o)
   );

   txrx_switch i_txrx_switch (
      .dsp_clk     (dsp_clk),
      .por_rst     (por_rst),
      .tx_sample_i (tx_sample_i),
      .rx_sample_i (rx_sample_i),
      .run_rx0_i   (run_rx0_i),
      .run_rx1_i   (run_rx1_i),
      .tx_mode_o   (tx_mode),
      .rx_active_o (rx_active),
      .rx_sample_o (rx_sample_o),
      .atr_o       (atr_o)
   );

   vita_timer #(.SR_TIME64(SR_TIME64)) i_vita_timer (
      .dsp_clk         (dsp_clk),
      .por_rst         (por_rst),
      .set_stb_i       (set_stb),
      .set_i           (set_data),
      .pps_i           (pps_i),
      .vita_time_o     (vita_time),
      .vita_time_pps_o (vita_time_pps)
   );

   readback_mux i_readback_mux (
      .dsp_clk         (dsp_clk),
      .por_rst         (por_rst),
      .rb_req_i        (rb_req_i),
      .rb_addr_i       (rb_addr_i),
      .vita_time_i     (vita_time),
      .vita_time_pps_i (vita_time_pps),
      .clk_status_i    (clk_status_i),
      .link_up_i       (link_up_i),
      .button_i        (button_i),
      .rb_ack_o        (rb_ack_o),
      .rb_data_o       (rb_data_o)
   );

endmodule

//--- verilog/readback_mux.sv
// Readback port for the host. A four-phase req/ack transfer returns one
// 32-bit word selected by rb_addr_i: compatibility number, interrupt status,
// current time or PPS time. Slots without a source read as all ones.

module readback_mux
   import radio_ctrl_pkg::*;
(
   input  logic             dsp_clk,
   input  logic             por_rst,
   input  logic             rb_req_i,
   input  logic [RB_AW-1:0] rb_addr_i,
   input  logic [63:0]      vita_time_i,
   input  logic [63:0]      vita_time_pps_i,
   input  logic             clk_status_i,
   input  logic             link_up_i,
   input  logic             button_i,
   output logic             rb_ack_o,
   output logic [31:0]      rb_data_o
);

   logic [31:0] irq_word;
   logic [31:0] rb_word;
   logic        new_req;

   // Bit 12 stays clear
   assign irq_word = {18'd0, button_i, 1'b0, clk_status_i, link_up_i, 10'd0};

   always_comb begin
      case (rb_addr_i)
         RB_COMPAT:  rb_word = COMPAT_NUM;
         RB_IRQ:     rb_word = irq_word;
         RB_TIME_HI: rb_word = vita_time_i[63:32];
         RB_TIME_LO: rb_word = vita_time_i[31:0];
         RB_PPS_HI:  rb_word = vita_time_pps_i[63:32];
         RB_PPS_LO:  rb_word = vita_time_pps_i[31:0];
         default:    rb_word = RB_FILL;
      endcase
   end

   ///////////////////////////////////////////////////////////////////////
   // Handshake

   assign new_req = rb_req_i & ~rb_ack_o;

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         rb_ack_o <= 1'b0;
      end else begin
         rb_ack_o <= rb_req_i;
      end
   end

   // Word sampled once and held for the whole ack phase
   always_ff @(posedge dsp_clk) begin
      if (new_req) begin
         rb_data_o <= rb_word;
      end
   end

endmodule

//--- verilog/vita_timer.sv
// 64-bit VITA time counter. It advances once per dsp_clk cycle and is set
// by writing the high word, which is staged, then the low word, which loads
// both halves. A synchronized PPS rising edge captures the current time.

module vita_timer
   import radio_ctrl_pkg::*;
#(
   parameter int SR_TIME64 = SR_TIME64_DEF
) (
   input  logic        dsp_clk,
   input  logic        por_rst,
   input  logic        set_stb_i,
   input  set_req_t    set_i,
   input  logic        pps_i,
   output logic [63:0] vita_time_o,
   output logic [63:0] vita_time_pps_o
);

   localparam logic [SET_AW-1:0] ADDR_HI = SET_AW'(SR_TIME64 + TIME_HI_OFF);
   localparam logic [SET_AW-1:0] ADDR_LO = SET_AW'(SR_TIME64 + TIME_LO_OFF);

   logic [31:0] time_hi_stage;
   logic        wr_hi;
   logic        wr_lo;
   logic [1:0]  pps_sync;
   logic        pps_d;
   logic        pps_edge;

   assign wr_hi = set_stb_i && (set_i.addr == ADDR_HI);
   assign wr_lo = set_stb_i && (set_i.addr == ADDR_LO);

   ///////////////////////////////////////////////////////////////////////
   // Time counter

   always_ff @(posedge dsp_clk) begin
      if (wr_hi) begin
         time_hi_stage <= set_i.data;
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         vita_time_o <= '0;
      end else if (wr_lo) begin
         vita_time_o <= {time_hi_stage, set_i.data};
      end else begin
         vita_time_o <= vita_time_o + 64'd1;
      end
   end

   ///////////////////////////////////////////////////////////////////////
   // PPS capture

   // Two flops into dsp_clk, one more for the edge
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         pps_sync <= 2'b00;
         pps_d    <= 1'b0;
      end else begin
         pps_sync <= {pps_sync[0], pps_i};
         pps_d    <= pps_sync[1];
      end
   end

   assign pps_edge = pps_sync[1] & ~pps_d;

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         vita_time_pps_o <= '0;
      end else if (pps_edge) begin
         vita_time_pps_o <= vita_time_o;
      end
   end

endmodule

//--- verilog/txrx_switch.sv
// TX/RX antenna switch driven by magic transmit samples. The -1,-1 sample
// enters TX mode and +1,+1 returns to RX. In TX mode every outgoing receive
// sample is replaced by the TX magic word.

module txrx_switch
   import radio_ctrl_pkg::*;
(
   input  logic    dsp_clk,
   input  logic    por_rst,
   input  sample_u tx_sample_i,
   input  sample_u rx_sample_i,
   input  logic    run_rx0_i,
   input  logic    run_rx1_i,
   output logic    tx_mode_o,
   output logic    rx_active_o,
   output sample_u rx_sample_o,
   output atr_t    atr_o
);

   logic magic_tx;
   logic magic_rx;
   logic run_rx0_d1;
   logic run_rx1_d1;

   // Both halves must match
   assign magic_tx = (tx_sample_i.iq.i == MAGIC_TX[31:16]) &&
                     (tx_sample_i.iq.q == MAGIC_TX[15:0]);
   assign magic_rx = (tx_sample_i.iq.i == MAGIC_RX[31:16]) &&
                     (tx_sample_i.iq.q == MAGIC_RX[15:0]);

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         tx_mode_o  <= 1'b0;
         run_rx0_d1 <= 1'b0;
         run_rx1_d1 <= 1'b0;
      end else begin
         if (magic_tx) begin
            tx_mode_o <= 1'b1;
         end else if (magic_rx) begin
            tx_mode_o <= 1'b0;
         end
         run_rx0_d1 <= run_rx0_i;
         run_rx1_d1 <= run_rx1_i;
      end
   end

   // Receive samples are forced to the magic word while transmitting
   always_ff @(posedge dsp_clk) begin
      rx_sample_o.raw <= tx_mode_o ? MAGIC_TX : rx_sample_i.raw;
   end

   assign rx_active_o = run_rx0_d1 | run_rx1_d1;
   assign atr_o.tx    = tx_mode_o;
   assign atr_o.rx    = rx_active_o;

endmodule

//--- verilog/misc_ctrl_regs.sv
// Misc control registers on the settings bus: clock generator, SERDES,
// ADC and PHY reset lines, plus the software LED value and the LED source
// mask. The LED outputs mix hardware status and software bits per mask bit.

module misc_ctrl_regs
   import radio_ctrl_pkg::*;
#(
   parameter int SR_MISC = SR_MISC_DEF
) (
   input  logic         dsp_clk,
   input  logic         por_rst,
   input  logic         set_stb_i,
   input  set_req_t     set_i,
   input  logic         tx_mode_i,
   input  logic         rx_active_i,
   input  logic         clk_status_i,
   input  logic         link_up_i,
   output clock_ctrl_t  clock_ctrl_o,
   output serdes_ctrl_t serdes_ctrl_o,
   output adc_ctrl_t    adc_ctrl_o,
   output logic         phy_reset_n_o,
   output logic [7:0]   leds_o
);

   localparam logic [SET_AW-1:0] ADDR_CLK     = SET_AW'(SR_MISC + MISC_CLK_OFF);
   localparam logic [SET_AW-1:0] ADDR_SERDES  = SET_AW'(SR_MISC + MISC_SERDES_OFF);
   localparam logic [SET_AW-1:0] ADDR_ADC     = SET_AW'(SR_MISC + MISC_ADC_OFF);
   localparam logic [SET_AW-1:0] ADDR_LED_SW  = SET_AW'(SR_MISC + MISC_LED_SW_OFF);
   localparam logic [SET_AW-1:0] ADDR_PHY     = SET_AW'(SR_MISC + MISC_PHY_OFF);
   localparam logic [SET_AW-1:0] ADDR_LED_SRC = SET_AW'(SR_MISC + MISC_LED_SRC_OFF);

   logic       phy_reset;
   logic [7:0] led_sw;
   logic [7:0] led_src;
   logic [7:0] led_hw;

   ///////////////////////////////////////////////////////////////////////
   // Register writes

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         clock_ctrl_o  <= '0;
         serdes_ctrl_o <= '0;
         adc_ctrl_o    <= '0;
         led_sw        <= '0;
         phy_reset     <= 1'b0;
         led_src       <= LED_SRC_RESET;
      end else if (set_stb_i) begin
         case (set_i.addr)
            ADDR_CLK:     clock_ctrl_o  <= clock_ctrl_t'(set_i.data[4:0]);
            ADDR_SERDES:  serdes_ctrl_o <= serdes_ctrl_t'(set_i.data[3:0]);
            ADDR_ADC:     adc_ctrl_o    <= adc_ctrl_t'(set_i.data[3:0]);
            ADDR_LED_SW:  led_sw        <= set_i.data[7:0];
            ADDR_PHY:     phy_reset     <= set_i.data[0];
            ADDR_LED_SRC: led_src       <= set_i.data[7:0];
            default: ;
         endcase
      end
   end

   // PHY reset pin is active low
   assign phy_reset_n_o = ~phy_reset;

   ///////////////////////////////////////////////////////////////////////
   // LED mix

   // Bit 0 has no LED behind it
   assign led_hw = {3'b000, tx_mode_i, rx_active_i, clk_status_i, link_up_i, 1'b0};

   // Mask bit 1 picks hardware status, 0 picks the software value
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

endmodule

//--- verilog/settings_port.sv
// Host side of the settings bus. A four-phase req/ack transfer is turned
// into one write strobe with its address and data, one cycle wide, that
// every register block sees and decodes for itself.

module settings_port
   import radio_ctrl_pkg::*;
(
   input  logic     dsp_clk,
   input  logic     por_rst,
   input  logic     set_req_i,
   input  set_req_t set_i,
   output logic     set_ack_o,
   output logic     set_stb_o,
   output set_req_t set_o
);

   logic new_req;

   // Request seen while the previous ack has dropped
   assign new_req = set_req_i & ~set_ack_o;

   ///////////////////////////////////////////////////////////////////////
   // Handshake

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         set_ack_o <= 1'b0;
         set_stb_o <= 1'b0;
      end else begin
         // Ack follows req, so it falls one cycle after req falls
         set_ack_o <= set_req_i;
         set_stb_o <= new_req;
      end
   end

   // Address and data captured once per transfer
   always_ff @(posedge dsp_clk) begin
      if (new_req) begin
         set_o <= set_i;
      end
   end

endmodule

//--- verilog/radio_ctrl_pkg.sv
// Shared definitions for the dsp_clk control plane of the radio core.
// Holds the settings register map, readback slots, bus widths and the
// structs that carry control lines and samples between the blocks.

package radio_ctrl_pkg;

   // Default base addresses of the register groups
   localparam int SR_MISC_DEF   = 0;
   localparam int SR_TIME64_DEF = 10;

   // Settings and readback bus widths
   localparam int SET_AW = 8;
   localparam int SET_DW = 32;
   localparam int RB_AW  = 4;

   // Major in the upper half, minor in the lower half
   localparam logic [31:0] COMPAT_NUM = {16'd10, 16'd1};

   localparam logic [31:0] MAGIC_TX      = 32'h8001_8001;
   localparam logic [31:0] MAGIC_RX      = 32'h7fff_7fff;
   localparam logic [7:0]  LED_SRC_RESET = 8'h1e;
   localparam logic [31:0] RB_FILL       = 32'hffff_ffff;

   // Misc register offsets from SR_MISC
   localparam int MISC_CLK_OFF     = 0;
   localparam int MISC_SERDES_OFF  = 1;
   localparam int MISC_ADC_OFF     = 2;
   localparam int MISC_LED_SW_OFF  = 3;
   localparam int MISC_PHY_OFF     = 4;
   localparam int MISC_LED_SRC_OFF = 6;

   // Time register offsets from SR_TIME64
   localparam int TIME_HI_OFF = 0;
   localparam int TIME_LO_OFF = 1;

   // Readback slots
   localparam logic [RB_AW-1:0] RB_COMPAT  = 4'd0;
   localparam logic [RB_AW-1:0] RB_IRQ     = 4'd1;
   localparam logic [RB_AW-1:0] RB_TIME_HI = 4'd2;
   localparam logic [RB_AW-1:0] RB_TIME_LO = 4'd3;
   localparam logic [RB_AW-1:0] RB_PPS_HI  = 4'd4;
   localparam logic [RB_AW-1:0] RB_PPS_LO  = 4'd5;

   typedef struct packed {
      logic [SET_AW-1:0] addr;
      logic [SET_DW-1:0] data;
   } set_req_t;

   typedef struct packed {
      logic       clock_ready;
      logic [1:0] clk_en;
      logic [1:0] clk_sel;
   } clock_ctrl_t;

   typedef struct packed {
      logic enable;
      logic prbsen;
      logic loopen;
      logic rx_en;
   } serdes_ctrl_t;

   typedef struct packed {
      logic oe_a;
      logic on_a;
      logic oe_b;
      logic on_b;
   } adc_ctrl_t;

   typedef struct packed {
      logic tx;
      logic rx;
   } atr_t;

   typedef struct packed {
      logic [15:0] i;
      logic [15:0] q;
   } iq_t;

   // Raw word on the receive path, I/Q halves in the switch
   typedef union packed {
      logic [31:0] raw;
      iq_t         iq;
   } sample_u;

endpackage
